// ==== design/uartPkg.sv ====
// frame constants, FIFO sizing, byte and command types, status bits, FSM state enums
package uartPkg;

	//////////////////////////////
	// serial frame
	//////////////////////////////
	localparam int dataBits   = 8;	// 8N1 only
	localparam int overSample = 16;	// ticks per bit
	localparam int stopTicks  = 16;	// one stop bit
	localparam int baudDiv    = 4;	// clk cycles per tick, kept small for sim

	// byte FIFOs
	localparam int fifoDepth   = 16;
	localparam int fifoAddrLen = 4;	// log2 of fifoDepth

	typedef logic [dataBits-1:0] uartByte_t;

	//////////////////////////////
	// host side
	//////////////////////////////
	typedef enum logic [1:0] {cmdRead, cmdWrite, cmdStatus} hostCmd_t;

	// bit positions in the status byte
	localparam int statRxAvail = 0;
	localparam int statTxFull  = 1;
	localparam int statOverrun = 2;

	// serial engine states
	typedef enum logic [1:0] {idle, start, data, stop} rxState_t;
	typedef enum logic [1:0] {txIdle, txStart, txData, txStop} txState_t;

endpackage

// ==== design/fifoIf.sv ====
// byte FIFO bundle with writer, reader and storage modports
`timescale 1ns/1ps

interface fifoIf import uartPkg::*; ();

	logic      push;	// write strobe
	uartByte_t wrData;
	logic      full;

	logic      pop;	// read strobe, head advances next cycle
	uartByte_t rdData;	// always the head entry
	logic      empty;

	// producer side
	modport writer
	(
		output push, wrData,
		input  full
	);

	// consumer side
	modport reader
	(
		output pop,
		input  rdData, empty
	);

	// the FIFO itself
	modport store
	(
		input  push, wrData, pop,
		output full, rdData, empty
	);

endinterface

// ==== design/baudGen.sv ====
// oversampling tick generator for both serial directions
`timescale 1ns/1ps

module baudGen import uartPkg::*;
(
	input  logic clk,
	input  logic reset,
	output logic sTick
);

	logic [$clog2(baudDiv)-1:0] divCnt;	// modulo baudDiv

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			divCnt <= '0;
		else if (divCnt == baudDiv - 1)
			divCnt <= '0;	// wrap
		else
			divCnt <= divCnt + 1'b1;
	end

	// one clk wide, once per wrap
	assign sTick = (divCnt == baudDiv - 1);

endmodule

// ==== design/uartFifo.sv ====
// synchronous byte FIFO with full and empty flags
`timescale 1ns/1ps

module uartFifo import uartPkg::*;
(
	input  logic clk,
	input  logic reset,
	fifoIf.store port
);

	uartByte_t mem [fifoDepth];	// storage, no reset
	logic [fifoAddrLen-1:0] wrPtr, rdPtr;	// wrap naturally
	logic [fifoAddrLen:0] count;	// 0..fifoDepth
	logic doPush, doPop;

	assign doPush = port.push & ~port.full;	// ignore when full
	assign doPop  = port.pop & ~port.empty;	// ignore when empty

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doPush)
				wrPtr <= wrPtr + 1'b1;
			if (doPop)
				rdPtr <= rdPtr + 1'b1;
			count <= count + doPush - doPop;	// both at once leaves count alone
		end
	end

	always_ff @(posedge clk)
	begin
		if (doPush)
			mem[wrPtr] <= port.wrData;
	end

	assign port.rdData = mem[rdPtr];	// head, fall-through
	assign port.full   = (count == fifoDepth);
	assign port.empty  = (count == 0);

	assert property (@(posedge clk) disable iff (reset) port.full |-> !port.push)
		else $error("%t uartFifo push while full", $time);
	assert property (@(posedge clk) disable iff (reset) port.empty |-> !port.pop)
		else $error("%t uartFifo pop while empty", $time);

endmodule

// ==== design/uartRec.sv ====
// oversampling serial receiver, pushes each finished byte into the rx FIFO
`timescale 1ns/1ps

module uartRec import uartPkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic sTick,
	input  logic rx,
	fifoIf.writer rxFifo,
	output logic overrun	// one-clk pulse, byte lost
);

	rxState_t stateReg, stateNext;
	logic [$clog2(overSample)-1:0] sReg, sNext;	// tick counter
	logic [$clog2(dataBits)-1:0] nReg, nNext;	// bit counter
	uartByte_t bReg, bNext;	// shift register
	logic [1:0] rxSync;	// async input
	logic rxIn;
	logic doneTick;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			rxSync   <= 2'b11;	// line idles high
			stateReg <= idle;
			sReg     <= '0;
			nReg     <= '0;
			bReg     <= '0;
		end
		else
		begin
			rxSync   <= {rxSync[0], rx};
			stateReg <= stateNext;
			sReg     <= sNext;
			nReg     <= nNext;
			bReg     <= bNext;
		end
	end

	assign rxIn = rxSync[1];

	//////////////////////////////
	// next state
	//////////////////////////////
	always_comb
	begin
		stateNext = stateReg;
		sNext     = sReg;
		nNext     = nReg;
		bNext     = bReg;
		doneTick  = 1'b0;
		case (stateReg)
			idle:
				if (!rxIn)
				begin
					stateNext = start;	// falling edge of start bit
					sNext     = '0;
				end
			start:
				if (sTick)
				begin
					if (sReg == overSample/2 - 1)
					begin
						// middle of start bit
						stateNext = rxIn ? idle : data;	// glitch goes back to idle
						sNext     = '0;
						nNext     = '0;
					end
					else
						sNext = sReg + 1'b1;
				end
			data:
				if (sTick)
				begin
					if (sReg == overSample - 1)
					begin
						sNext = '0;
						bNext = {rxIn, bReg[dataBits-1:1]};	// lsb first
						if (nReg == dataBits - 1)
							stateNext = stop;
						else
							nNext = nReg + 1'b1;
					end
					else
						sNext = sReg + 1'b1;
				end
			stop:
				if (sTick)
				begin
					if (sReg == stopTicks - 1)
					begin
						stateNext = idle;
						doneTick  = 1'b1;	// frame complete
					end
					else
						sNext = sReg + 1'b1;
				end
			default: stateNext = idle;
		endcase
	end

	// hand off to FIFO or flag the loss
	always_comb
	begin
		rxFifo.push = doneTick & ~rxFifo.full;
		overrun     = doneTick & rxFifo.full;
	end

	assign rxFifo.wrData = bReg;

	// counters step once per tick, so a tick must be a single clk
	assert property (@(posedge clk) disable iff (reset) sTick |=> !sTick)
		else $error("%t uartRec oversampling tick wider than one clk", $time);

endmodule

// ==== design/uartXmit.sv ====
// serial transmitter, drains the tx FIFO frame by frame
`timescale 1ns/1ps

module uartXmit import uartPkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic sTick,
	fifoIf.reader txFifo,
	output logic tx
);

	txState_t stateReg, stateNext;
	logic [$clog2(overSample)-1:0] sReg, sNext;
	logic [$clog2(dataBits)-1:0] nReg, nNext;
	uartByte_t bReg, bNext;	// outgoing byte
	logic txReg, txNext;	// registered line, no glitches

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= txIdle;
			sReg     <= '0;
			nReg     <= '0;
			bReg     <= '0;
			txReg    <= 1'b1;	// mark
		end
		else
		begin
			stateReg <= stateNext;
			sReg     <= sNext;
			nReg     <= nNext;
			bReg     <= bNext;
			txReg    <= txNext;
		end
	end

	always_comb
	begin
		stateNext  = stateReg;
		sNext      = sReg;
		nNext      = nReg;
		bNext      = bReg;
		txNext     = txReg;
		txFifo.pop = 1'b0;
		case (stateReg)
			txIdle:
			begin
				txNext = 1'b1;
				if (!txFifo.empty)
				begin
					txFifo.pop = 1'b1;	// take head now
					bNext      = txFifo.rdData;
					sNext      = '0;
					stateNext  = txStart;
				end
			end
			txStart:
			begin
				txNext = 1'b0;
				if (sTick)
				begin
					if (sReg == overSample - 1)
					begin
						stateNext = txData;
						sNext     = '0;
						nNext     = '0;
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			txData:
			begin
				txNext = bReg[0];	// lsb first
				if (sTick)
				begin
					if (sReg == overSample - 1)
					begin
						sNext = '0;
						bNext = bReg >> 1;
						if (nReg == dataBits - 1)
							stateNext = txStop;
						else
							nNext = nReg + 1'b1;
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			txStop:
			begin
				txNext = 1'b1;
				if (sTick)
				begin
					if (sReg == stopTicks - 1)
					begin
						if (!txFifo.empty)
						begin
							// back to back, skip idle
							txFifo.pop = 1'b1;
							bNext      = txFifo.rdData;
							sNext      = '0;
							stateNext  = txStart;
						end
						else
							stateNext = txIdle;
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			default: stateNext = txIdle;
		endcase
	end

	assign tx = txReg;

	assert property (@(posedge clk) disable iff (reset) (stateReg == txIdle) |-> tx)
		else $error("%t uartXmit line low while idle", $time);

endmodule

// ==== design/uartHostPort.sv ====
// four-phase req/ack command port, status byte and sticky overrun
`timescale 1ns/1ps

module uartHostPort import uartPkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic req,
	input  hostCmd_t cmd,
	input  uartByte_t wrData,
	output logic ack,
	output uartByte_t rdData,
	input  logic overrun,
	fifoIf.reader rxFifo,
	fifoIf.writer txFifo
);

	typedef enum logic [1:0] {waitReq, doCmd, waitRelease} hostState_t;

	hostState_t stateReg;
	logic overrunReg;	// sticky
	logic cmdDone;	// command finishes this cycle
	uartByte_t statusByte;

	always_comb
	begin
		statusByte = '0;
		statusByte[statRxAvail] = ~rxFifo.empty;
		statusByte[statTxFull]  = txFifo.full;
		statusByte[statOverrun] = overrunReg;
	end

	//////////////////////////////
	// command execution
	//////////////////////////////
	always_comb
	begin
		cmdDone     = 1'b0;
		txFifo.push = 1'b0;
		rxFifo.pop  = 1'b0;
		if (stateReg == doCmd)
		begin
			case (cmd)
				cmdWrite:
				begin
					cmdDone     = ~txFifo.full;	// back-pressure
					txFifo.push = ~txFifo.full;
				end
				cmdRead:
				begin
					cmdDone    = ~rxFifo.empty;	// wait for a byte
					rxFifo.pop = ~rxFifo.empty;
				end
				default: cmdDone = 1'b1;	// status or unused code
			endcase
		end
	end

	assign txFifo.wrData = wrData;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg   <= waitReq;
			ack        <= 1'b0;
			overrunReg <= 1'b0;
		end
		else
		begin
			// new loss wins over the clearing read
			overrunReg <= overrun | (overrunReg & ~(cmdDone && cmd == cmdStatus));
			case (stateReg)
				waitReq:
					if (req)
						stateReg <= doCmd;
				doCmd:
					if (cmdDone)
					begin
						stateReg <= waitRelease;
						ack      <= 1'b1;
					end
				waitRelease:
					if (!req)
					begin
						stateReg <= waitReq;
						ack      <= 1'b0;
					end
				default: stateReg <= waitReq;
			endcase
		end
	end

	// read data, valid while ack
	always_ff @(posedge clk)
	begin
		if (cmdDone && cmd != cmdWrite)
			rdData <= (cmd == cmdRead) ? rxFifo.rdData : statusByte;
	end

	// host keeps req up until it sees ack
	assert property (@(posedge clk) disable iff (reset) req && !ack |=> req || ack)
		else $error("%t uartHostPort req dropped before ack", $time);

endmodule

// ==== design/uartCore.sv ====
// UART top level, tick generator, receiver, transmitter, FIFOs and host port
`timescale 1ns/1ps

module uartCore import uartPkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic req,
	input  hostCmd_t cmd,
	input  uartByte_t wrData,
	output logic ack,
	output uartByte_t rdData,
	input  logic rx,
	output logic tx
);

	logic sTick;	// shared oversampling strobe
	logic overrun;	// rx byte dropped

	fifoIf rxFifo ();	// receiver to host
	fifoIf txFifo ();	// host to transmitter

	//////////////////////////////
	// timebase and serial engines
	//////////////////////////////
	baudGen baudGen_i (.clk, .reset, .sTick);

	uartRec uartRec_i (.clk, .reset, .sTick, .rx, .rxFifo(rxFifo.writer), .overrun);

	uartXmit uartXmit_i (.clk, .reset, .sTick, .txFifo(txFifo.reader), .tx);

	// byte buffers
	uartFifo rxBuf_i (.clk, .reset, .port(rxFifo.store));
	uartFifo txBuf_i (.clk, .reset, .port(txFifo.store));

	//////////////////////////////
	// processor side
	//////////////////////////////
	uartHostPort uartHostPort_i
	(
		.clk, .reset,
		.req, .cmd, .wrData, .ack, .rdData,
		.overrun,
		.rxFifo(rxFifo.reader),
		.txFifo(txFifo.writer)
	);

endmodule

// ==== tb/clockGen.sv ====
// testbench clock and power-on reset
`timescale 1ns/1ps

module clockGen
(
	output logic clk,
	output logic reset
);

	localparam int halfPeriod  = 10;	// 20 ns period
	localparam int resetCycles = 16;

	initial
	begin
		clk = 1'b0;
		forever #halfPeriod clk = ~clk;
	end

	// release away from the active edge
	initial
	begin
		reset = 1'b1;
		repeat (resetCycles) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

// ==== tb/uartTb.sv ====
// UART core testbench, stimulus table, host handshake, line monitor, checks and timeout
`timescale 1ns/1ps

module uartTb import uartPkg::*;
();

	localparam int bitCycles     = overSample * baudDiv;	// clk per serial bit
	localparam int frameCycles   = (dataBits + 2) * bitCycles;	// start, data, stop
	localparam int timeoutCycles = 40 * frameCycles + 16;	// 40 frames plus reset
	localparam logic [1:0] chkNone = 2'd0, chkFixed = 2'd1, chkSent = 2'd2;

	// one table row, repeated rep times
	typedef struct packed
	{
		logic [3:0] testNum;
		hostCmd_t   cmd;
		logic [4:0] rep;
		logic       randData;	// payload from $random
		uartByte_t  data;
		logic [1:0] chk;	// none, fixed value, or order of writes
		uartByte_t  expData;
		logic       waitLine;	// all sent frames received first
	} step_t;

	localparam int numSteps = 14;

	logic clk, reset;
	logic req, ack, tx, rxLine;
	logic loopBack, serialOut;	// line source select, bit-banged line
	hostCmd_t cmd;
	uartByte_t wrData, rdData;
	step_t steps [numSteps];
	uartByte_t sentQ [$];	// bytes written, in order
	uartByte_t d, got, exp, lastByte;
	int seed, curTest, frameCount, txCount, cycleCount;
	int checks, errors, testChecks, testErrors, testsRun, testsFailed;

	clockGen clockGen_i (.clk, .reset);

	assign rxLine = loopBack ? tx : serialOut;	// tx back to rx unless bit-banging

	uartCore dut_i (.clk, .reset, .req, .cmd, .wrData, .ack, .rdData, .rx(rxLine), .tx);

	//////////////////////////////
	// helpers
	//////////////////////////////

	// four-phase req/ack, driven on falling edge
	task automatic runHandshake(input hostCmd_t c, input uartByte_t wd, output uartByte_t rd);
		@(negedge clk);
		cmd    = c;
		wrData = wd;
		req    = 1'b1;
		while (!ack)
			@(negedge clk);
		rd  = rdData;	// valid while ack high
		req = 1'b0;
		while (ack)
			@(negedge clk);
	endtask

	task automatic checkByte(input uartByte_t gotV, input uartByte_t expV, input string what);
		checks++;
		testChecks++;
		assert (gotV === expV)
		else
		begin
			$display("mismatch at %0t ns: %s got %h expected %h", $time, what, gotV, expV);
			errors++;
			testErrors++;
		end
	endtask

	// one line per finished test
	task automatic reportTest();
		testsRun++;
		if (testErrors != 0)
			testsFailed++;
		$display("test %0d %s, %0d checks, %0d errors", curTest,
			(testErrors == 0) ? "pass" : "fail", testChecks, testErrors);
		testChecks = 0;
		testErrors = 0;
	endtask

	// 8N1 frame on the rx input, lsb first
	task automatic sendFrame(input uartByte_t b);
		@(negedge clk);
		serialOut = 1'b0;	// start bit
		repeat (bitCycles) @(negedge clk);
		for (int i = 0; i < dataBits; i++)
		begin
			serialOut = b[i];
			repeat (bitCycles) @(negedge clk);
		end
		checks++;
		testChecks++;
		// read still pending, req held and no ack yet
		assert (req && !ack)
		else
		begin
			$display("read acknowledged at %0t ns before any byte arrived", $time);
			errors++;
			testErrors++;
		end
		serialOut = 1'b1;	// stop bit
		repeat (bitCycles) @(negedge clk);
	endtask

	// counts frames on the rx line, done just before the next start edge
	always
	begin
		@(negedge rxLine);
		repeat (frameCycles - bitCycles / 4) @(posedge clk);
		frameCount++;
	end

	// run limit
	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= timeoutCycles)
		begin
			$display("timeout, run stopped after %0d cycles without finishing", cycleCount);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	//////////////////////////////
	// stimulus table and main flow
	//////////////////////////////
	initial
	begin
		req        = 1'b0;
		cmd        = cmdStatus;
		wrData     = '0;
		loopBack   = 1'b1;
		serialOut  = 1'b1;	// idle mark
		seed       = 54;
		cycleCount = 0;
		frameCount = 0;
		txCount    = 0;
		checks     = 0;
		errors     = 0;
		testChecks = 0;
		testErrors = 0;
		testsRun   = 0;
		testsFailed = 0;
		// test, cmd, rep, rand, data, chk, expected, wait for line
		steps[0]  = '{4'd1, cmdStatus, 5'd1, 1'b0, 8'h00, chkFixed, 8'h00, 1'b0};
		steps[1]  = '{4'd2, cmdWrite, 5'd1, 1'b0, 8'hA5, chkNone, 8'h00, 1'b0};
		steps[2]  = '{4'd2, cmdRead, 5'd1, 1'b0, 8'h00, chkSent, 8'h00, 1'b0};
		steps[3]  = '{4'd3, cmdWrite, 5'd5, 1'b1, 8'h00, chkNone, 8'h00, 1'b0};
		steps[4]  = '{4'd3, cmdRead, 5'd5, 1'b0, 8'h00, chkSent, 8'h00, 1'b0};
		steps[5]  = '{4'd4, cmdWrite, 5'd1, 1'b0, 8'h3C, chkNone, 8'h00, 1'b0};
		steps[6]  = '{4'd4, cmdStatus, 5'd1, 1'b0, 8'h00, chkFixed, 8'h01, 1'b1};	// rxAvail
		steps[7]  = '{4'd4, cmdRead, 5'd1, 1'b0, 8'h00, chkSent, 8'h00, 1'b0};
		steps[8]  = '{4'd4, cmdStatus, 5'd1, 1'b0, 8'h00, chkFixed, 8'h00, 1'b0};
		steps[9]  = '{4'd5, cmdWrite, 5'd18, 1'b1, 8'h00, chkNone, 8'h00, 1'b0};
		steps[10] = '{4'd5, cmdStatus, 5'd1, 1'b0, 8'h00, chkFixed, 8'h05, 1'b1};	// overrun set
		steps[11] = '{4'd5, cmdStatus, 5'd1, 1'b0, 8'h00, chkFixed, 8'h01, 1'b0};	// now clear
		steps[12] = '{4'd5, cmdRead, 5'd16, 1'b0, 8'h00, chkSent, 8'h00, 1'b0};
		steps[13] = '{4'd5, cmdStatus, 5'd1, 1'b0, 8'h00, chkFixed, 8'h00, 1'b0};
		wait (reset === 1'b0);
		curTest = steps[0].testNum;
		for (int i = 0; i < numSteps; i++)
		begin
			if (steps[i].testNum != curTest)
			begin
				reportTest();
				curTest = steps[i].testNum;
				sentQ.delete();	// dropped bytes never come back
			end
			if (steps[i].waitLine)
				wait (frameCount >= txCount);
			for (int r = 0; r < steps[i].rep; r++)
			begin
				d = steps[i].randData ? uartByte_t'($random(seed)) : steps[i].data;
				runHandshake(steps[i].cmd, d, got);
				if (steps[i].cmd == cmdWrite)
				begin
					sentQ.push_back(d);
					txCount++;
				end
				else if (steps[i].chk == chkFixed)
					checkByte(got, steps[i].expData, $sformatf("step %0d status", i));
				else if (steps[i].chk == chkSent)
				begin
					exp = sentQ.pop_front();
					checkByte(got, exp, $sformatf("step %0d read %0d", i, r));
				end
			end
		end
		reportTest();

		// read waits on an empty rx FIFO, byte comes in on the line afterwards
		curTest = 6;
		lastByte = uartByte_t'($random(seed));
		@(negedge clk);
		loopBack = 1'b0;
		fork
			runHandshake(cmdRead, 8'h00, got);
			begin
				wait (req);
				sendFrame(lastByte);
			end
		join
		checkByte(got, lastByte, "blocked read");
		reportTest();

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			testsRun, testsFailed, checks, errors);
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// ==== list.f ====
design/uartPkg.sv
design/fifoIf.sv
design/baudGen.sv
design/uartFifo.sv
design/uartRec.sv
design/uartXmit.sv
design/uartHostPort.sv
design/uartCore.sv
tb/clockGen.sv
tb/uartTb.sv

// ==== Makefile ====
# Verilator flow for the UART core
VERILATOR ?= verilator
TOP       ?= uartTb
RTL_TOP   ?= uartCore
FILELIST  ?= list.f
BUILDDIR  ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAILMSG   := *** TEST FAILED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR) -o V$(TOP)

run: build
	@./$(BUILDDIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -qF '$(FAILMSG)' $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILDDIR) $(LOG)
